// File: sim.f
+incdir+include
hw/mem_pkg.sv
hw/fetch_pkg.sv
hw/line_fetcher.sv
hw/fetch_pc_ctrl.sv
hw/inst_queue.sv
hw/fetch_top.sv
dv/tb_clk_gen.sv
dv/bmem_model.sv
dv/fetch_tb.sv

// File: dv/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_tb
import mem_pkg::*;
import fetch_pkg::*;
();

    localparam logic [31:0] MEM_PATTERN = 32'h3c5a_0ff1;

    localparam int N_SEQ   = 40;
    localparam int N_BP    = 24;
    localparam int N_RDR   = 16;
    localparam int N_BURST = 16;
    localparam int N_RAND  = 100;
    localparam int N_TOTAL = 1 + N_SEQ + N_BP + N_RDR + N_BURST + N_RAND;
    localparam int CYCLE_LIMIT = 200 * N_TOTAL + 500;

    logic   clk;
    logic   rst;
    addr_t  bmem_addr;
    logic   bmem_read;
    logic   bmem_ready;
    addr_t  bmem_raddr;
    beat_t  bmem_rdata;
    logic   bmem_rvalid;
    logic   redirect;
    addr_t  redirect_pc;
    order_t redirect_order;
    logic   inst_ren;
    logic   inst_valid;
    addr_t  inst_pc;
    inst_t  inst_word;
    order_t inst_order;

    addr_t  exp_pc;         // reference model of the stream
    order_t exp_order;
    integer seed;
    int     cycles = 0;

    tb_clk_gen clk_gen (.clk_o(clk), .rst_o(rst));

    bmem_model #(.MEM_PATTERN(MEM_PATTERN)) mem (
        .clk_i         (clk),
        .rst_i         (rst),
        .bmem_addr_i   (bmem_addr),
        .bmem_read_i   (bmem_read),
        .bmem_ready_o  (bmem_ready),
        .bmem_raddr_o  (bmem_raddr),
        .bmem_rdata_o  (bmem_rdata),
        .bmem_rvalid_o (bmem_rvalid)
    );

    fetch_top dut (
        .clk              (clk),
        .rst              (rst),
        .bmem_addr_o      (bmem_addr),
        .bmem_read_o      (bmem_read),
        .bmem_ready_i     (bmem_ready),
        .bmem_raddr_i     (bmem_raddr),
        .bmem_rdata_i     (bmem_rdata),
        .bmem_rvalid_i    (bmem_rvalid),
        .redirect_i       (redirect),
        .redirect_pc_i    (redirect_pc),
        .redirect_order_i (redirect_order),
        .inst_ren_i       (inst_ren),
        .inst_valid_o     (inst_valid),
        .inst_pc_o        (inst_pc),
        .inst_o           (inst_word),
        .inst_order_o     (inst_order)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", cycles);
            $display("Something failed");
            $fatal(1, "run aborted");
        end
    end

    task automatic check_eq(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Something failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // pops n entries, checking each head against the reference model
    task automatic pop_insts(input int n, input bit random_ren);
        int popped;
        bit ren;
        popped = 0;
        while (popped < n) begin
            @(negedge clk);
            ren = random_ren ? ($random(seed) & 1) : 1'b1;   // ignored while empty
            if (ren && inst_valid) begin
                check_eq("inst_pc_o", inst_pc, exp_pc);
                check_eq("inst_order_o", inst_order, exp_order);
                check_eq("inst_o", inst_word, exp_pc ^ MEM_PATTERN);
                exp_pc    = exp_pc + 32'd4;
                exp_order = exp_order + 64'd1;
                popped++;
            end
            inst_ren = ren;
        end
        @(negedge clk);
        inst_ren = 1'b0;
    endtask

    // starts on a falling edge, redirect is sampled at the next rising edge
    task automatic redirect_to(input addr_t pc, input order_t order);
        inst_ren       = 1'b0;
        redirect       = 1'b1;
        redirect_pc    = pc;
        redirect_order = order;
        exp_pc         = pc;
        exp_order      = order;
        @(negedge clk);
        redirect = 1'b0;
        check_eq("inst_valid_o", inst_valid, 1'b0);    // queue flushed
    endtask

    task automatic test_reset();
        @(negedge rst);
        check_eq("bmem_read_o", bmem_read, 1'b0);
        check_eq("inst_valid_o", inst_valid, 1'b0);
        exp_pc    = `RESET_PC;
        exp_order = '0;
        pop_insts(1, 1'b0);
    endtask

    task automatic test_sequential();
        pop_insts(N_SEQ, 1'b0);     // crosses several lines
    endtask

    task automatic test_back_pressure();
        repeat (60) begin
            @(negedge clk);
            inst_ren = 1'b0;
        end
        check_eq("inst_valid_o", inst_valid, 1'b1);
        check_eq("inst_pc_o", inst_pc, exp_pc);
        pop_insts(N_BP, 1'b0);
    endtask

    task automatic test_redirect_mid_line();
        redirect_to(32'h0001_2354, 64'h0000_0100_0000_0000);
        pop_insts(N_RDR, 1'b0);
    endtask

    task automatic test_redirect_outstanding();
        redirect_to(32'h0040_0000, 64'd5000);  // this line gets abandoned
        do begin
            @(negedge clk);
        end while (bmem_read !== 1'b1);
        check_eq("bmem_addr_o", bmem_addr, 32'h0040_0000);
        // read low again means the bus took it at the last rising edge
        do begin
            @(negedge clk);
        end while (bmem_read === 1'b1);
        redirect_to(32'h0080_0108, 64'd7000);
        pop_insts(N_BURST, 1'b0);
    endtask

    task automatic test_random_stream();
        pop_insts(35, 1'b1);
        redirect_to(32'h0000_2000, 64'd90000);
        pop_insts(35, 1'b1);
        // near a line end, and the order wraps
        redirect_to(32'h0000_31f8, 64'hffff_ffff_ffff_fff0);
        pop_insts(N_RAND - 70, 1'b1);
    endtask

    initial begin
        seed           = 32'h78c8;
        inst_ren       = 1'b0;
        redirect       = 1'b0;
        redirect_pc    = '0;
        redirect_order = '0;
        exp_pc         = `RESET_PC;
        exp_order      = '0;

        test_reset();
        $display("reset test done");
        test_sequential();
        $display("sequential stream done");
        test_back_pressure();
        $display("back-pressure test done");
        test_redirect_mid_line();
        $display("mid-line redirect done");
        test_redirect_outstanding();
        $display("redirect during burst done");
        test_random_stream();
        $display("random stream done");

        $display("Everything OK");
        $finish;
    end

endmodule : fetch_tb

// File: dv/bmem_model.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module bmem_model
import mem_pkg::*;
#(
    parameter logic [31:0] MEM_PATTERN = 32'h0
)(
    input   logic   clk_i,
    input   logic   rst_i,
    input   addr_t  bmem_addr_i,
    input   logic   bmem_read_i,
    output  logic   bmem_ready_o,
    output  addr_t  bmem_raddr_o,
    output  beat_t  bmem_rdata_o,
    output  logic   bmem_rvalid_o
);

    integer seed;
    addr_t  pending [$];    // accepted line reads

    // ready about three cycles in four
    always @(negedge clk_i) begin
        bmem_ready_o = (($random(seed) & 3) != 0);
    end

    always @(posedge clk_i) begin
        if (!rst_i && bmem_read_i === 1'b1 && bmem_ready_o) begin
            pending.push_back(bmem_addr_i);
        end
    end

    initial begin
        addr_t line;
        int    delay;
        seed          = 32'h78c8;
        bmem_ready_o  = 1'b0;
        bmem_raddr_o  = '0;
        bmem_rdata_o  = '0;
        bmem_rvalid_o = 1'b0;
        forever begin
            wait (pending.size() != 0);
            line  = pending.pop_front();
            delay = 2 + (($random(seed) & 32'h7fff_ffff) % 5);   // 2 to 6 cycles
            repeat (delay) @(negedge clk_i);
            for (int k = 0; k < `BEATS_PER_LINE; k++) begin
                bmem_rvalid_o = 1'b1;
                bmem_raddr_o  = line;
                // lower word sits at the lower address
                bmem_rdata_o  = {(line + 8 * k + 4) ^ MEM_PATTERN,
                                 (line + 8 * k) ^ MEM_PATTERN};
                @(negedge clk_i);
            end
            bmem_rvalid_o = 1'b0;
        end
    end

endmodule : bmem_model

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 4
)(
    output  logic   clk_o,
    output  logic   rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // released on a falling edge, away from the sampling edge
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule : tb_clk_gen

// File: hw/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
import mem_pkg::*;
import fetch_pkg::*;
(
    input   logic           clk,
    input   logic           rst,

    // memory bus
    output  addr_t          bmem_addr_o,
    output  logic           bmem_read_o,
    input   logic           bmem_ready_i,
    input   addr_t          bmem_raddr_i,
    input   beat_t          bmem_rdata_i,
    input   logic           bmem_rvalid_i,

    // redirect from the back end
    input   logic           redirect_i,
    input   addr_t          redirect_pc_i,
    input   order_t         redirect_order_i,

    // instruction stream out
    input   logic           inst_ren_i,
    output  logic           inst_valid_o,
    output  addr_t          inst_pc_o,
    output  inst_t          inst_o,
    output  order_t         inst_order_o
);

    // fetcher <-> pc control
    logic       line_req;
    addr_t      req_addr;
    logic       line_valid;
    addr_t      line_addr;
    line_t      line_data;

    // pc control <-> queue
    logic       enq;
    addr_t      enq_pc;
    inst_t      enq_inst;
    order_t     enq_order;
    logic       q_space;

    line_fetcher line_fetcher_i (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .line_req_i    (line_req),
        .req_addr_i    (req_addr),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .line_valid_o  (line_valid),
        .line_addr_o   (line_addr),
        .line_data_o   (line_data)
    );

    fetch_pc_ctrl fetch_pc_ctrl_i (
        .clk              (clk),
        .rst              (rst),
        .redirect_i       (redirect_i),
        .redirect_pc_i    (redirect_pc_i),
        .redirect_order_i (redirect_order_i),
        .line_req_o       (line_req),
        .req_addr_o       (req_addr),
        .line_valid_i     (line_valid),
        .line_addr_i      (line_addr),
        .line_data_i      (line_data),
        .q_space_i        (q_space),
        .enq_o            (enq),
        .enq_pc_o         (enq_pc),
        .enq_inst_o       (enq_inst),
        .enq_order_o      (enq_order)
    );

    inst_queue inst_queue_i (
        .clk          (clk),
        .rst          (rst),
        .redirect_i   (redirect_i),
        .enq_i        (enq),
        .enq_pc_i     (enq_pc),
        .enq_inst_i   (enq_inst),
        .enq_order_i  (enq_order),
        .q_space_o    (q_space),
        .deq_i        (inst_ren_i),
        .valid_o      (inst_valid_o),
        .pc_o         (inst_pc_o),
        .inst_o       (inst_o),
        .order_o      (inst_order_o)
    );

endmodule : fetch_top

// File: hw/inst_queue.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module inst_queue
import mem_pkg::*;
import fetch_pkg::*;
#(
    parameter int DEPTH = `IQ_DEPTH
)(
    input   logic           clk,
    input   logic           rst,
    input   logic           redirect_i,

    input   logic           enq_i,
    input   addr_t          enq_pc_i,
    input   inst_t          enq_inst_i,
    input   order_t         enq_order_i,
    output  logic           q_space_o,

    input   logic           deq_i,
    output  logic           valid_o,
    output  addr_t          pc_o,
    output  inst_t          inst_o,
    output  order_t         order_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;

    addr_t          pc_mem    [DEPTH];
    inst_t          inst_mem  [DEPTH];
    order_t         order_mem [DEPTH];

    ptr_t           head;
    ptr_t           tail;
    logic [CNT_W-1:0] count;
    logic           full;
    logic           do_enq;
    logic           do_deq;

    assign full      = (count == CNT_W'(DEPTH));
    assign q_space_o = !full;
    assign valid_o   = (count != '0);

    assign do_deq = deq_i && valid_o;
    assign do_enq = enq_i && (!full || do_deq);   // full queue can swap an entry

    assign pc_o    = pc_mem[head];
    assign inst_o  = inst_mem[head];
    assign order_o = order_mem[head];

    always_ff @(posedge clk) begin
        if (rst || redirect_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_enq) begin
                tail <= (tail == ptr_t'(DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (do_deq) begin
                head <= (head == ptr_t'(DEPTH - 1)) ? '0 : head + 1'b1;
            end
            count <= count + CNT_W'(do_enq) - CNT_W'(do_deq);
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            pc_mem[tail]    <= enq_pc_i;
            inst_mem[tail]  <= enq_inst_i;
            order_mem[tail] <= enq_order_i;
        end
    end

    // the producer must watch q_space_o
    no_enq_when_full: assert property (@(posedge clk) disable iff (rst || redirect_i)
        (enq_i && full) |-> deq_i);

endmodule : inst_queue

// File: hw/fetch_pc_ctrl.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_pc_ctrl
import mem_pkg::*;
import fetch_pkg::*;
(
    input   logic           clk,
    input   logic           rst,

    // redirect
    input   logic           redirect_i,
    input   addr_t          redirect_pc_i,
    input   order_t         redirect_order_i,

    // line fetcher side
    output  logic           line_req_o,
    output  addr_t          req_addr_o,
    input   logic           line_valid_i,
    input   addr_t          line_addr_i,
    input   line_t          line_data_i,

    // instruction queue side
    input   logic           q_space_i,
    output  logic           enq_o,
    output  addr_t          enq_pc_o,
    output  inst_t          enq_inst_o,
    output  order_t         enq_order_o
);

    localparam int OFF_BITS = $clog2(`LINE_BYTES);

    addr_t      pc;
    order_t     order;
    addr_t      pc_line;

    // serial line buffer, tagged with its own line address
    line_t      buf_data;
    addr_t      buf_tag;
    logic       buf_valid;
    logic       buf_hit;
    logic       buf_load;
    word_idx_t  word_idx;
    logic       advance;

    assign pc_line  = {pc[31:OFF_BITS], {OFF_BITS{1'b0}}};
    assign word_idx = pc[OFF_BITS-1:2];
    assign buf_hit  = buf_valid && (buf_tag == pc_line);

    // stale lines from an older pc are dropped here
    assign buf_load = line_valid_i && (line_addr_i == pc_line);

    assign advance = buf_hit && q_space_i;

    assign line_req_o = !buf_hit;
    assign req_addr_o = pc_line;

    assign enq_o       = advance;       // queue drops it during a redirect
    assign enq_pc_o    = pc;
    assign enq_order_o = order;
    assign enq_inst_o  = buf_data[$bits(inst_t)*word_idx +: $bits(inst_t)];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= `RESET_PC;
            order <= '0;
        end else if (redirect_i) begin
            pc    <= redirect_pc_i;
            order <= redirect_order_i;
        end else if (advance) begin
            pc    <= pc + 32'd4;
            order <= order + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid <= 1'b0;
        end else if (redirect_i) begin
            buf_valid <= 1'b0;
        end else if (buf_load) begin
            buf_valid <= 1'b1;
        end else if (advance && word_idx == word_idx_t'(`WORDS_PER_LINE - 1)) begin
            buf_valid <= 1'b0;          // last word used up
        end
    end

    always_ff @(posedge clk) begin
        if (buf_load && !redirect_i) begin
            buf_data <= line_data_i;
            buf_tag  <= line_addr_i;
        end
    end

    // redirect targets come from outside and must keep this
    pc_word_aligned: assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00);

endmodule : fetch_pc_ctrl

// File: hw/line_fetcher.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module line_fetcher
import mem_pkg::*;
(
    input   logic           clk,
    input   logic           rst,
    input   logic           redirect_i,

    // line request from the pc side
    input   logic           line_req_i,
    input   addr_t          req_addr_i,

    // memory bus
    output  addr_t          bmem_addr_o,
    output  logic           bmem_read_o,
    input   logic           bmem_ready_i,
    input   addr_t          bmem_raddr_i,
    input   beat_t          bmem_rdata_i,
    input   logic           bmem_rvalid_i,

    // finished line
    output  logic           line_valid_o,
    output  addr_t          line_addr_o,
    output  line_t          line_data_o
);

    localparam int OFF_BITS = $clog2(`LINE_BYTES);

    fetch_state_e   state;
    addr_t          addr_q;         // line being fetched
    beat_cnt_t      beat_cnt;
    logic           discard;        // burst belongs to a flushed stream
    logic           beat_match;
    logic           burst_done;

    assign bmem_read_o = (state == FETCH_REQUEST);
    assign bmem_addr_o = addr_q;
    assign line_addr_o = addr_q;

    assign beat_match = bmem_rvalid_i && (bmem_raddr_i == addr_q);
    assign burst_done = (state == FETCH_COLLECT) && beat_match &&
                        (beat_cnt == beat_cnt_t'(`BEATS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= FETCH_IDLE;
            beat_cnt     <= '0;
            discard      <= 1'b0;
            line_valid_o <= 1'b0;
        end else begin
            line_valid_o <= 1'b0;
            unique case (state)
                FETCH_IDLE: begin
                    // line_valid_o still high means the miss is about to clear
                    if (line_req_i && !line_valid_o && !redirect_i) begin
                        state <= FETCH_REQUEST;
                    end
                end
                FETCH_REQUEST: begin
                    if (bmem_ready_i) begin
                        state    <= FETCH_COLLECT;
                        beat_cnt <= '0;
                        discard  <= redirect_i;    // taken together with a flush
                    end else if (redirect_i) begin
                        state <= FETCH_IDLE;       // never reached the bus
                    end
                end
                FETCH_COLLECT: begin
                    if (redirect_i) begin
                        discard <= 1'b1;
                    end
                    if (beat_match) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    if (burst_done) begin
                        state        <= FETCH_IDLE;
                        line_valid_o <= !discard && !redirect_i;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // address latched when leaving idle
    always_ff @(posedge clk) begin
        if (state == FETCH_IDLE) begin
            addr_q <= req_addr_i;
        end
    end

    // beat k lands in bytes 8k..8k+7, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == FETCH_COLLECT && beat_match) begin
            line_data_o <= {bmem_rdata_i, line_data_o[$bits(line_t)-1:$bits(beat_t)]};
        end
    end

    // one burst at a time on the bus
    read_quiet_during_burst: assert property (@(posedge clk) disable iff (rst)
        (bmem_read_o && bmem_ready_i) |=> (!bmem_read_o until_with burst_done));

    read_addr_aligned: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |-> (bmem_addr_o[OFF_BITS-1:0] == '0));

endmodule : line_fetcher

// File: hw/fetch_pkg.sv
`include "fetch_consts.svh"

package fetch_pkg;

    // one instruction word
    typedef logic [31:0] inst_t;

    // program order, same width as the retire order in the cpu
    typedef logic [63:0] order_t;

    // selects a word inside a line
    typedef logic [$clog2(`WORDS_PER_LINE)-1:0] word_idx_t;

endpackage : fetch_pkg

// File: hw/mem_pkg.sv
`include "fetch_consts.svh"

package mem_pkg;

    // byte address on the memory bus
    typedef logic [31:0] addr_t;

    // one bus beat and one full line
    typedef logic [63:0]                beat_t;
    typedef logic [`LINE_BYTES*8-1:0]   line_t;

    // counts beats within one burst
    typedef logic [$clog2(`BEATS_PER_LINE)-1:0] beat_cnt_t;

    // line fetcher FSM
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQUEST,     // read held until the bus takes it
        FETCH_COLLECT      // waiting on the burst beats
    } fetch_state_e;

endpackage : mem_pkg

// File: include/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// first fetch address after reset
`define RESET_PC        32'hAAAAA000

// line geometry
`define LINE_BYTES      32
`define BEATS_PER_LINE  4      // 64-bit bus beats per line
`define WORDS_PER_LINE  8      // 32-bit words per line

// instruction queue depth
`define IQ_DEPTH        8

`endif
